// File: verilog.f
rtl/cache_cfg_pkg.sv
rtl/cache_bus_pkg.sv
rtl/dram_rsp_queue.sv
rtl/flush_ctrl.sv
rtl/cache_bank.sv
rtl/uncached_bypass.sv
rtl/perf_counters.sv
rtl/cache_top.sv
dv/cache_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --timescale 1ns/100ps -f verilog.f --top-module cache_tb \
    && ./obj_dir/Vcache_tb | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: dv/cache_tb.sv
`default_nettype none

module cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam int NUM_LINES   = 64;
    localparam int DRSQ_DEPTH  = 4;
    localparam int IDX_W       = $clog2(NUM_LINES);
    localparam int TAG_W       = LINE_ADDR_W - IDX_W;
    localparam int N_OPS       = 300;
    localparam int TIMEOUT     = 400;
    localparam int HIT_LATENCY = 2;

    logic         clk;
    logic         reset;
    logic         flush;
    logic         core_req_valid;
    core_req_t    core_req;
    logic         core_req_ready;
    logic         core_rsp_valid;
    core_rsp_t    core_rsp;
    logic         dram_req_valid;
    dram_req_t    dram_req;
    logic         dram_req_ready;
    logic         dram_rsp_valid;
    dram_rsp_t    dram_rsp;
    logic         dram_rsp_ready;
    perf_counts_t perf;

    integer seed      = 32'hb311;
    integer dram_seed = ~32'hb311;

    int errors      = 0;
    int checks      = 0;
    int n_reads     = 0;
    int n_writes    = 0;
    int n_misses    = 0;
    int dram_rd_cnt = 0;
    int dram_wr_cnt = 0;

    // Reference word memory, DRAM line memory and shadow tags
    word_t            ref_mem  [word_addr_t];
    line_t            dram_mem [line_addr_t];
    logic             shadow_valid [NUM_LINES];
    logic [TAG_W-1:0] shadow_tag   [NUM_LINES];

    cache_top #(
        .NUM_LINES  (NUM_LINES),
        .DRSQ_DEPTH (DRSQ_DEPTH)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .perf           (perf)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Memory models

    // Power-up contents depend on the full word address
    function automatic word_t init_word(word_addr_t addr);
        return word_t'(addr) * 32'h9e37_79b1 + 32'h0bad_cafe;
    endfunction

    function automatic word_t ref_read(word_addr_t addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : init_word(addr);
    endfunction

    function automatic line_t dram_read_line(line_addr_t ln);
        line_t ln_data;
        if (dram_mem.exists(ln)) return dram_mem[ln];
        for (int w = 0; w < LINE_WORDS; w++) begin
            ln_data[w*WORD_W +: WORD_W] = init_word({ln, word_sel_t'(w)});
        end
        return ln_data;
    endfunction

    function automatic line_t dram_write_line(line_t old, dram_req_t req);
        line_t ln_data;
        ln_data = old;
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (req.byteen[i]) ln_data[i*8 +: 8] = req.data[i*8 +: 8];
        end
        return ln_data;
    endfunction

    // DRAM with random ready stalls and a random response delay
    initial begin : dram_model
        dram_rsp_t   pending;
        logic        rsp_pending;
        logic        rsp_acc;
        int          rsp_delay;
        logic [31:0] r;
        dram_req_ready = 1'b0;
        dram_rsp_valid = 1'b0;
        dram_rsp       = '0;
        pending        = '0;
        rsp_pending    = 1'b0;
        rsp_acc        = 1'b0;
        rsp_delay      = 0;
        forever begin
            @(posedge clk);
            #2;
            if (rsp_acc) dram_rsp_valid = 1'b0;
            if (rsp_pending && rsp_delay == 0) begin
                dram_rsp_valid = 1'b1;
                dram_rsp       = pending;
                rsp_pending    = 1'b0;
            end else if (rsp_pending) begin
                rsp_delay--;
            end
            rsp_acc = dram_rsp_valid && dram_rsp_ready;
            r = $random(dram_seed);
            dram_req_ready = (r[1:0] != 2'd0);
            // Handshake completes at the coming edge
            if (dram_req_valid && dram_req_ready) begin
                if (dram_req.rw) begin
                    dram_mem[dram_req.addr] = dram_write_line(dram_read_line(dram_req.addr),
                                                              dram_req);
                    dram_wr_cnt++;
                end else begin
                    assert (!(rsp_pending || dram_rsp_valid)) else begin
                        errors++;
                        $display("Second DRAM read issued while one was outstanding");
                    end
                    dram_rd_cnt++;
                    pending.data = dram_read_line(dram_req.addr);
                    pending.tag  = dram_req.addr;
                    rsp_pending  = 1'b1;
                    rsp_delay    = int'(r[4:2]);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking and run control

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d, reads %0d, writes %0d, read misses %0d",
                 checks, errors, n_reads, n_writes, n_misses);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timed out waiting for %s", what);
        finish_run();
    endtask

    task automatic wait_ready(input string what, output int cycles);
        cycles = 0;
        while (!core_req_ready && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
            assert (!core_rsp_valid) else begin
                errors++;
                $display("Core response appeared while waiting for %s", what);
            end
        end
        if (!core_req_ready) stop_on_timeout(what);
    endtask

    task automatic wait_rsp(output int cycles);
        cycles = 0;
        while (!core_rsp_valid && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!core_rsp_valid) stop_on_timeout("core response");
    endtask

    // Returns just after the accepting edge
    task automatic send_req(input core_req_t req);
        int cycles;
        core_req       = req;
        core_req_valid = 1'b1;
        wait_ready("request acceptance", cycles);
        @(posedge clk);
        #2;
        core_req_valid = 1'b0;
    endtask

    task automatic clear_shadow();
        for (int i = 0; i < NUM_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic run_op(input core_req_t req);
        line_addr_t       ln;
        logic [IDX_W-1:0] idx;
        logic             cached;
        logic             hit;
        word_t            wd;
        int               rd0;
        int               wr0;
        int               cycles;
        ln     = req.addr[WORD_ADDR_W-1:WSEL_W];
        idx    = ln[IDX_W-1:0];
        cached = !ln[LINE_ADDR_W-1];
        hit    = cached && shadow_valid[idx] && (shadow_tag[idx] == ln[LINE_ADDR_W-1:IDX_W]);
        rd0    = dram_rd_cnt;
        wr0    = dram_wr_cnt;
        send_req(req);
        if (req.rw) begin
            n_writes++;
            wd = ref_read(req.addr);
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (req.byteen[b]) wd[b*8 +: 8] = req.data[b*8 +: 8];
            end
            ref_mem[req.addr] = wd;
            wait_ready("write completion", cycles);
            check_value("DRAM writes per write", dram_wr_cnt - wr0, 1);
            check_value("DRAM reads per write", dram_rd_cnt - rd0, 0);
        end else begin
            n_reads++;
            if (cached && !hit) begin
                n_misses++;
                shadow_valid[idx] = 1'b1;
                shadow_tag[idx]   = ln[LINE_ADDR_W-1:IDX_W];
            end
            wait_rsp(cycles);
            check_value("read data", core_rsp.data, ref_read(req.addr));
            check_value("read tag", 32'(core_rsp.tag), 32'(req.tag));
            // Strobe seen after edge n is taken by the core at edge n+1
            if (hit) check_value("hit latency", cycles + 1, HIT_LATENCY);
            check_value("DRAM reads per read", dram_rd_cnt - rd0, hit ? 0 : 1);
            check_value("DRAM writes per read", dram_wr_cnt - wr0, 0);
        end
    endtask

    // 16 cached lines on 4 indices, 4 uncached lines
    task automatic random_req(output core_req_t req);
        logic [31:0] r;
        logic [31:0] d;
        line_addr_t  ln;
        r = $random(seed);
        d = $random(seed);
        if (r[2:0] == 3'd0) begin
            ln = {1'b1, 25'd0, r[4:3]};
        end else begin
            ln = {20'd0, r[6:5], r[8:7], 4'h5};
        end
        req.rw     = r[9];
        req.addr   = {ln, r[11:10]};
        req.byteen = r[12] ? r[16:13] : 4'hf;
        req.data   = d;
        req.tag    = r[20:17];
    endtask

    task automatic flush_check();
        line_addr_t lines [$];
        core_req_t  req;
        int         cycles;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (shadow_valid[i]) lines.push_back({shadow_tag[i], IDX_W'(i)});
        end
        checks++;
        assert (lines.size() > 0) else begin
            errors++;
            $display("No cached line was valid before the flush");
        end
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        check_value("core_req_ready during flush", 32'(core_req_ready), 0);
        clear_shadow();
        wait_ready("end of flush sweep", cycles);
        // Every line cached before the flush must miss now
        foreach (lines[k]) begin
            req      = '0;
            req.addr = {lines[k], 2'd1};
            req.tag  = core_tag_t'(k);
            run_op(req);
        end
    endtask

    initial begin : stimulus
        core_req_t req;
        int        cycles;
        reset          = 1'b1;
        flush          = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        clear_shadow();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("core_req_ready after reset", 32'(core_req_ready), 0);
        check_value("dram_req_valid after reset", 32'(dram_req_valid), 0);
        check_value("core_rsp_valid after reset", 32'(core_rsp_valid), 0);
        check_value("dram_rsp_ready after reset", 32'(dram_rsp_ready), 1);
        wait_ready("end of reset sweep", cycles);
        checks++;
        assert (cycles >= NUM_LINES) else begin
            errors++;
            $display("core_req_ready rose %0d cycles after reset, before the sweep ended",
                     cycles);
        end
        for (int i = 0; i < N_OPS; i++) begin
            if (i == N_OPS / 2) flush_check();
            random_req(req);
            run_op(req);
        end
        @(posedge clk);
        #2;
        check_value("perf reads", perf.reads, n_reads);
        check_value("perf writes", perf.writes, n_writes);
        check_value("perf read misses", perf.read_misses, n_misses);
        finish_run();
    end

endmodule

`default_nettype wire

// File: rtl/cache_top.sv
`default_nettype none

module cache_top #(
    parameter int NUM_LINES  = 64,
    parameter int DRSQ_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        core_req_valid,
    input  cache_bus_pkg::core_req_t    core_req,
    output logic                        core_req_ready,
    output logic                        core_rsp_valid,
    output cache_bus_pkg::core_rsp_t    core_rsp,
    output logic                        dram_req_valid,
    output cache_bus_pkg::dram_req_t    dram_req,
    input  logic                        dram_req_ready,
    input  logic                        dram_rsp_valid,
    input  cache_bus_pkg::dram_rsp_t    dram_rsp,
    output logic                        dram_rsp_ready,
    output cache_bus_pkg::perf_counts_t perf
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam int IDX_W = $clog2(NUM_LINES);

    logic             bank_req_valid;
    core_req_t        bank_req;
    logic             bank_idle;
    logic             bank_rsp_valid;
    core_rsp_t        bank_rsp;
    logic             bank_dram_req_valid;
    dram_req_t        bank_dram_req;
    logic             bank_dram_req_ready;
    logic             fill_valid;
    line_t            fill_data;
    logic             drsq_valid;
    dram_rsp_t        drsq_rsp;
    logic             drsq_pop;
    logic             flush_valid;
    logic [IDX_W-1:0] flush_index;
    logic             read_miss;

    //////////////////////////////////////////////////////////////////////

    dram_rsp_queue #(
        .DRSQ_DEPTH (DRSQ_DEPTH)
    ) u_drsq (
        .clk            (clk),
        .reset          (reset),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .rsp_valid      (drsq_valid),
        .rsp            (drsq_rsp),
        .rsp_pop        (drsq_pop)
    );

    uncached_bypass u_bypass (
        .clk                 (clk),
        .reset               (reset),
        .core_req_valid      (core_req_valid),
        .core_req            (core_req),
        .core_req_ready      (core_req_ready),
        .core_rsp_valid      (core_rsp_valid),
        .core_rsp            (core_rsp),
        .bank_req_valid      (bank_req_valid),
        .bank_req            (bank_req),
        .bank_idle           (bank_idle),
        .bank_rsp_valid      (bank_rsp_valid),
        .bank_rsp            (bank_rsp),
        .bank_dram_req_valid (bank_dram_req_valid),
        .bank_dram_req       (bank_dram_req),
        .bank_dram_req_ready (bank_dram_req_ready),
        .fill_valid          (fill_valid),
        .fill_data           (fill_data),
        .rsp_valid           (drsq_valid),
        .rsp                 (drsq_rsp),
        .rsp_pop             (drsq_pop),
        .dram_req_valid      (dram_req_valid),
        .dram_req            (dram_req),
        .dram_req_ready      (dram_req_ready)
    );

    //////////////////////////////////////////////////////////////////////

    flush_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) u_flush (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .flush_valid (flush_valid),
        .flush_index (flush_index)
    );

    cache_bank #(
        .NUM_LINES (NUM_LINES)
    ) u_bank (
        .clk                 (clk),
        .reset               (reset),
        .bank_req_valid      (bank_req_valid),
        .bank_req            (bank_req),
        .bank_idle           (bank_idle),
        .bank_rsp_valid      (bank_rsp_valid),
        .bank_rsp            (bank_rsp),
        .bank_dram_req_valid (bank_dram_req_valid),
        .bank_dram_req       (bank_dram_req),
        .bank_dram_req_ready (bank_dram_req_ready),
        .fill_valid          (fill_valid),
        .fill_data           (fill_data),
        .flush_valid         (flush_valid),
        .flush_index         (flush_index),
        .read_miss           (read_miss)
    );

    perf_counters u_perf (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_req_rw    (core_req.rw),
        .read_miss      (read_miss),
        .perf           (perf)
    );

endmodule

`default_nettype wire

// File: rtl/perf_counters.sv
`default_nettype none

module perf_counters (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        core_req_valid,
    input  logic                        core_req_ready,
    input  logic                        core_req_rw,
    input  logic                        read_miss,
    output cache_bus_pkg::perf_counts_t perf
);

    logic accept;

    assign accept = core_req_valid && core_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            perf <= '0;
        end else begin
            if (accept && !core_req_rw) perf.reads <= perf.reads + 1'b1;
            if (accept && core_req_rw) perf.writes <= perf.writes + 1'b1;
            // Bank strobe marks cached read misses only
            if (read_miss) perf.read_misses <= perf.read_misses + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/uncached_bypass.sv
`default_nettype none

module uncached_bypass (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     core_req_valid,
    input  cache_bus_pkg::core_req_t core_req,
    output logic                     core_req_ready,
    output logic                     core_rsp_valid,
    output cache_bus_pkg::core_rsp_t core_rsp,
    output logic                     bank_req_valid,
    output cache_bus_pkg::core_req_t bank_req,
    input  logic                     bank_idle,
    input  logic                     bank_rsp_valid,
    input  cache_bus_pkg::core_rsp_t bank_rsp,
    input  logic                     bank_dram_req_valid,
    input  cache_bus_pkg::dram_req_t bank_dram_req,
    output logic                     bank_dram_req_ready,
    output logic                     fill_valid,
    output cache_cfg_pkg::line_t     fill_data,
    input  logic                     rsp_valid,
    input  cache_bus_pkg::dram_rsp_t rsp,
    output logic                     rsp_pop,
    output logic                     dram_req_valid,
    output cache_bus_pkg::dram_req_t dram_req,
    input  logic                     dram_req_ready
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [1:0] {IDLE, SEND, WAIT_RSP} state_t;

    state_t    state;
    core_req_t byp_req_q;
    core_rsp_t byp_rsp_q;
    logic      byp_rsp_valid_q;

    logic      accept;
    logic      uncached;
    logic      rsp_uncached;
    logic      byp_sent;

    // One request in flight across bank and bypass
    assign uncached       = core_req.addr[WORD_ADDR_W-1];
    assign core_req_ready = (state == IDLE) && bank_idle;
    assign accept         = core_req_valid && core_req_ready;

    assign bank_req_valid = accept && !uncached;
    assign bank_req       = core_req;

    // Bank requests win the DRAM port
    assign dram_req_valid      = bank_dram_req_valid || (state == SEND);
    assign dram_req            = bank_dram_req_valid ? bank_dram_req : make_line_req(byp_req_q);
    assign bank_dram_req_ready = dram_req_ready;
    assign byp_sent            = (state == SEND) && !bank_dram_req_valid && dram_req_ready;

    // Tag bit 27 set means the line belongs to the uncached region
    assign rsp_uncached = rsp.tag[LINE_ADDR_W-1];
    assign rsp_pop      = rsp_valid;
    assign fill_valid   = rsp_valid && !rsp_uncached;
    assign fill_data    = rsp.data;

    assign core_rsp_valid = bank_rsp_valid || byp_rsp_valid_q;
    assign core_rsp       = bank_rsp_valid ? bank_rsp : byp_rsp_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= IDLE;
            byp_rsp_valid_q <= 1'b0;
        end else begin
            byp_rsp_valid_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept && uncached) state <= SEND;
                end
                SEND: begin
                    if (byp_sent) state <= byp_req_q.rw ? IDLE : WAIT_RSP;
                end
                WAIT_RSP: begin
                    if (rsp_valid && rsp_uncached) begin
                        byp_rsp_valid_q <= 1'b1;
                        state           <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && uncached) byp_req_q <= core_req;
        if (state == WAIT_RSP) begin
            byp_rsp_q.data <= pick_word(rsp.data, byp_req_q.addr[WSEL_W-1:0]);
            byp_rsp_q.tag  <= byp_req_q.tag;
        end
    end

endmodule

`default_nettype wire

// File: rtl/cache_bank.sv
`default_nettype none

module cache_bank #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES)
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     bank_req_valid,
    input  cache_bus_pkg::core_req_t bank_req,
    output logic                     bank_idle,
    output logic                     bank_rsp_valid,
    output cache_bus_pkg::core_rsp_t bank_rsp,
    output logic                     bank_dram_req_valid,
    output cache_bus_pkg::dram_req_t bank_dram_req,
    input  logic                     bank_dram_req_ready,
    input  logic                     fill_valid,
    input  cache_cfg_pkg::line_t     fill_data,
    input  logic                     flush_valid,
    input  logic [IDX_W-1:0]         flush_index,
    output logic                     read_miss
);
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam int TAG_W = LINE_ADDR_W - IDX_W;

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] line_tag_t;
    typedef enum logic [1:0] {IDLE, LOOKUP, DRAM_SEND, FILL_WAIT} state_t;

    state_t     state;
    core_req_t  req_q;
    dram_req_t  dram_req_q;
    core_rsp_t  rsp_q;
    logic       rsp_valid_q;

    logic       valid_mem [NUM_LINES];
    line_tag_t  tag_mem   [NUM_LINES];
    line_t      line_mem  [NUM_LINES];

    line_addr_t req_line;
    index_t     req_index;
    line_tag_t  req_tag;
    word_sel_t  req_wsel;
    dram_req_t  line_req;
    logic       hit;

    // Byte-masked merge of a write-through request into a stored line
    function automatic line_t merge_line(line_t old, dram_req_t wr);
        line_t res;
        res = old;
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (wr.byteen[i]) res[i*8 +: 8] = wr.data[i*8 +: 8];
        end
        return res;
    endfunction

    assign req_line  = req_q.addr[WORD_ADDR_W-1:WSEL_W];
    assign req_index = req_line[IDX_W-1:0];
    assign req_tag   = req_line[LINE_ADDR_W-1:IDX_W];
    assign req_wsel  = req_q.addr[WSEL_W-1:0];
    assign line_req  = make_line_req(req_q);
    assign hit       = valid_mem[req_index] && (tag_mem[req_index] == req_tag);

    assign bank_idle           = (state == IDLE) && !flush_valid;
    assign bank_dram_req_valid = (state == DRAM_SEND);
    assign bank_dram_req       = dram_req_q;
    assign bank_rsp_valid      = rsp_valid_q;
    assign bank_rsp            = rsp_q;
    assign read_miss           = (state == LOOKUP) && !req_q.rw && !hit;

    //////////////////////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (bank_req_valid) state <= LOOKUP;
                end
                LOOKUP: begin
                    if (!req_q.rw && hit) begin
                        rsp_valid_q <= 1'b1;
                        state       <= IDLE;
                    end else begin
                        state <= DRAM_SEND;
                    end
                end
                DRAM_SEND: begin
                    if (bank_dram_req_ready) state <= req_q.rw ? IDLE : FILL_WAIT;
                end
                FILL_WAIT: begin
                    if (fill_valid) begin
                        rsp_valid_q <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && bank_req_valid) req_q <= bank_req;
        // Write-through for every write, line read for a read miss
        if (state == LOOKUP) dram_req_q <= line_req;
        if (state == LOOKUP || state == FILL_WAIT) begin
            rsp_q.tag  <= req_q.tag;
            rsp_q.data <= (state == FILL_WAIT) ? pick_word(fill_data, req_wsel)
                                               : pick_word(line_mem[req_index], req_wsel);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Arrays

    always_ff @(posedge clk) begin
        if (state == LOOKUP && req_q.rw && hit) begin
            line_mem[req_index] <= merge_line(line_mem[req_index], line_req);
        end
        if (state == FILL_WAIT && fill_valid) begin
            line_mem[req_index] <= fill_data;
            tag_mem[req_index]  <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (flush_valid) begin
            valid_mem[flush_index] <= 1'b0;
        end else if (state == FILL_WAIT && fill_valid) begin
            valid_mem[req_index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/flush_ctrl.sv
`default_nettype none

module flush_ctrl #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    output logic             flush_valid,
    output logic [IDX_W-1:0] flush_index
);

    // Steps one line index per cycle from reset or the strobe
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            flush_valid <= 1'b1;
            flush_index <= '0;
        end else if (flush_valid) begin
            if (flush_index == IDX_W'(NUM_LINES - 1)) begin
                flush_valid <= 1'b0;
            end
            flush_index <= flush_index + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dram_rsp_queue.sv
`default_nettype none

module dram_rsp_queue #(
    parameter int  DRSQ_DEPTH = 4,
    localparam int PTR_W      = $clog2(DRSQ_DEPTH),
    localparam int CNT_W      = $clog2(DRSQ_DEPTH + 1)
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dram_rsp_valid,
    input  cache_bus_pkg::dram_rsp_t dram_rsp,
    output logic                     dram_rsp_ready,
    output logic                     rsp_valid,
    output cache_bus_pkg::dram_rsp_t rsp,
    input  logic                     rsp_pop
);
    import cache_bus_pkg::*;

    dram_rsp_t        mem [DRSQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DRSQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign dram_rsp_ready = (count != CNT_W'(DRSQ_DEPTH));
    assign rsp_valid      = (count != '0);
    assign rsp            = mem[rd_ptr];
    assign push           = dram_rsp_valid && dram_rsp_ready;
    assign pop            = rsp_pop && rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= dram_rsp;
    end

endmodule

`default_nettype wire

// File: rtl/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    import cache_cfg_pkg::*;

    typedef struct packed {
        logic       rw;
        word_addr_t addr;
        byteen_t    byteen;
        word_t      data;
        core_tag_t  tag;
    } core_req_t;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    // Request tag is the line address itself
    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        line_byteen_t byteen;
        line_t        data;
    } dram_req_t;

    typedef struct packed {
        line_t      data;
        line_addr_t tag;
    } dram_rsp_t;

    typedef struct packed {
        count_t reads;
        count_t writes;
        count_t read_misses;
    } perf_counts_t;

    // Word request to line request with the write data replicated
    function automatic dram_req_t make_line_req(core_req_t req);
        dram_req_t line_req;
        word_sel_t wsel;
        wsel            = req.addr[WSEL_W-1:0];
        line_req.rw     = req.rw;
        line_req.addr   = req.addr[WORD_ADDR_W-1:WSEL_W];
        line_req.byteen = req.rw ? (line_byteen_t'(req.byteen) << (wsel * WORD_BYTES)) : '1;
        line_req.data   = {LINE_WORDS{req.data}};
        return line_req;
    endfunction

    function automatic word_t pick_word(line_t line, word_sel_t wsel);
        return line[wsel * WORD_W +: WORD_W];
    endfunction

endpackage

`default_nettype wire

// File: rtl/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

    // Storage geometry
    localparam int WORD_BYTES  = 4;
    localparam int LINE_WORDS  = 4;
    localparam int WORD_W      = 8 * WORD_BYTES;
    localparam int LINE_BYTES  = WORD_BYTES * LINE_WORDS;
    localparam int LINE_W      = 8 * LINE_BYTES;
    localparam int WSEL_W      = $clog2(LINE_WORDS);

    // Top word address bit marks the uncached region
    localparam int WORD_ADDR_W = 30;
    localparam int LINE_ADDR_W = WORD_ADDR_W - WSEL_W;

    localparam int CORE_TAG_W  = 4;
    localparam int COUNT_W     = 32;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [WORD_BYTES-1:0]  byteen_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [WSEL_W-1:0]      word_sel_t;
    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [LINE_BYTES-1:0]  line_byteen_t;
    typedef logic [CORE_TAG_W-1:0]  core_tag_t;
    typedef logic [COUNT_W-1:0]     count_t;

endpackage

`default_nettype wire
